/* Makefile */
# Verilator flow for the req/ack arbiter
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= arb_tb
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Test failed
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?=

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) \
		-f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) \
		-f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BIN)
	@$(BIN) > $(LOG) 2>&1 || echo "simulation aborted" >> $(LOG)
	@cat $(LOG)
	@if grep -q -e "$(FAIL_MSG)" -e "simulation aborted" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
logic/arb_cfg_pkg.sv
logic/arb_state_pkg.sv
logic/pick_if.sv
logic/onehot_priority.sv
logic/grant_timer.sv
logic/arb_fsm.sv
logic/arb_top.sv
tests/arb_props.sv
tests/arb_tb.sv

/* logic/arb_cfg_pkg.sv */
// ********************************************************************
// arbiter configuration package
// client count, hold limit and the vector types sized from them
// ********************************************************************

package arb_cfg_pkg;

  // number of requesting clients
  // each one owns a single req/ack pair on the top level
  localparam int NUM_CLIENTS = 8;

  // grant length in cycles at which the overrun flag rises
  localparam int HOLD_LIMIT = 16;

  // the counter must be able to hold HOLD_LIMIT itself
  // so one extra value on top of the limit
  localparam int HOLD_CNT_W = $clog2(HOLD_LIMIT + 1);

  // one bit per client
  // shared by req, ack, pending and pick
  typedef logic [NUM_CLIENTS-1:0] client_vec_t;

  // cycle count of the current grant, saturates at HOLD_LIMIT
  typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

endpackage : arb_cfg_pkg

/* logic/arb_fsm.sv */
// ********************************************************************
// grant sequencer
// runs the four-phase req/ack handshake toward all clients
// ********************************************************************

`timescale 1ns/1ps

module arb_fsm
  import arb_cfg_pkg::*;
  import arb_state_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  client_vec_t req,
  output client_vec_t ack,
  output logic        overrun,
  pick_if.seq         pk,
  output logic        run,
  input  logic        expired
);

  arb_state_t  state_q;
  arb_state_t  state_d;

  // one-hot grant register, drives ack directly
  client_vec_t grant_q;
  client_vec_t grant_d;

  // granted client has dropped its req
  logic        released;

  // picker only sees requests while the resource is free
  // during a grant the pending set is irrelevant
  assign pk.pending = (state_q == ST_IDLE) ? req : '0;

  // no bit of the granted client is still requesting
  assign released = ~|(grant_q & req);

  // grant loads on the edge after req is sampled in idle
  assign pk.commit = (state_q == ST_IDLE) && pk.pick_valid;

  always_comb begin
    state_d = state_q;
    grant_d = grant_q;
    case (state_q)
      ST_IDLE: begin
        // one idle cycle at least between two grants
        if (pk.pick_valid) begin
          grant_d = pk.pick;
          state_d = ST_GRANT;
        end
      end
      ST_GRANT: begin
        // ack falls one edge after the granted req falls
        // other pending requests wait for the next idle cycle
        if (released) begin
          grant_d = '0;
          state_d = ST_IDLE;
        end
      end
      default: begin
        grant_d = '0;
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      grant_q <= '0;
    end else begin
      state_q <= state_d;
      grant_q <= grant_d;
    end
  end

  assign ack = grant_q;

  // hold timer runs for the whole grant
  // it clears on its own once run drops
  assign run = (state_q == ST_GRANT);

  // overrun only reports, the grant is never revoked
  // masking with the state makes it fall together with ack
  assign overrun = (state_q == ST_GRANT) && expired;

endmodule : arb_fsm

/* logic/arb_state_pkg.sv */
// ********************************************************************
// grant sequencer state encoding
// ********************************************************************

package arb_state_pkg;

  // idle: resource free, waiting for any req
  // grant: one client holds the resource until its req drops
  typedef enum logic [0:0] {
    ST_IDLE  = 1'b0,
    ST_GRANT = 1'b1
  } arb_state_t;

endpackage : arb_state_pkg

/* logic/arb_top.sv */
// ********************************************************************
// eight-client resource arbiter, req/ack four-phase handshake
// ********************************************************************

`timescale 1ns/1ps

module arb_top import arb_cfg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  client_vec_t req,
  output client_vec_t ack,
  output logic        overrun
);

  // sequencer to hold timer
  logic run;
  logic expired;

  // sequencer to priority picker
  pick_if pk_bus ();

  // handshake and grant register
  arb_fsm i_fsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .overrun (overrun),
    .pk      (pk_bus.seq),
    .run     (run),
    .expired (expired)
  );

  // winner selection with direction memory
  onehot_priority i_pick (
    .clk   (clk),
    .rst_n (rst_n),
    .pk    (pk_bus.picker)
  );

  // grant length watch
  grant_timer i_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .expired (expired)
  );

endmodule : arb_top

/* logic/grant_timer.sv */
// ********************************************************************
// hold timer, counts grant cycles and flags an overrun at HOLD_LIMIT
// ********************************************************************

`timescale 1ns/1ps

module grant_timer import arb_cfg_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic expired
);

  hold_cnt_t cnt_q;
  hold_cnt_t cnt_d;

  // count up while a grant runs, stop at the limit
  // low run clears the count on the following edge
  always_comb begin
    if (!run) begin
      cnt_d = '0;
    end else if (cnt_q == hold_cnt_t'(HOLD_LIMIT)) begin
      cnt_d = cnt_q;
    end else begin
      cnt_d = cnt_q + hold_cnt_t'(1);
    end
  end

  // flag is registered from the next count
  // so it rises on the same edge the count reaches the limit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      expired <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      expired <= (cnt_d == hold_cnt_t'(HOLD_LIMIT));
    end
  end

endmodule : grant_timer

/* logic/onehot_priority.sv */
// ********************************************************************
// one-hot priority picker
// lowest or highest pending client wins, direction set by last winner
// ********************************************************************

`timescale 1ns/1ps

module onehot_priority import arb_cfg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  pick_if.picker pk
);

  // winner of the last committed grant
  // zero after reset, so the first scan goes lowest-first
  client_vec_t prev_q;

  // combinational scan result
  client_vec_t pick_vec;

  // highest-first whenever the last winner was not client 0
  // client 0 or no winner at all keeps the scan lowest-first
  logic        highest_first;

  assign highest_first = |prev_q[NUM_CLIENTS-1:1];

  // walk the clients in scan order
  // first pending bit seen wins, everything after it is masked
  always_comb begin
    int   idx;
    logic taken;
    taken    = 1'b0;
    pick_vec = '0;
    for (int i = 0; i < NUM_CLIENTS; i++) begin
      // map loop count onto the client index for either direction
      idx = highest_first ? (NUM_CLIENTS - 1 - i) : i;
      if (pk.pending[idx] && !taken) begin
        pick_vec[idx] = 1'b1;
        taken         = 1'b1;
      end
    end
  end

  assign pk.pick       = pick_vec;
  assign pk.pick_valid = |pk.pending;

  // remember the winner on the grant edge
  // this flips the direction for the next scan
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_q <= '0;
    end else if (pk.commit) begin
      prev_q <= pick_vec;
    end
  end

endmodule : onehot_priority

/* logic/pick_if.sv */
// ********************************************************************
// picker link between the grant sequencer and the priority picker
// ********************************************************************

`timescale 1ns/1ps

interface pick_if import arb_cfg_pkg::*; ();

  // requests offered for arbitration
  client_vec_t pending;

  // one-hot winner, zero when nothing is pending
  client_vec_t pick;

  // at least one bit of pending is set
  logic        pick_valid;

  // single-cycle pulse on the edge that loads a grant
  logic        commit;

  // sequencer side
  modport seq (
    output pending,
    output commit,
    input  pick,
    input  pick_valid
  );

  // picker side
  modport picker (
    input  pending,
    input  commit,
    output pick,
    output pick_valid
  );

endinterface : pick_if

/* tests/arb_props.sv */
// ********************************************************************
// handshake and one-hot properties, bound into the arbiter top
// ********************************************************************

`timescale 1ns/1ps

module arb_props import arb_cfg_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input client_vec_t req,
  input client_vec_t ack,
  input logic        overrun
);

  // at most one client owns the resource
  a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ack))
    else $error("ack has more than one bit set");

  // a new ack bit needs a request on that client
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    (ack & ~$past(ack) & ~$past(req)) == '0)
    else $error("ack rose for a client without req");

  // grant holds while the owner still requests
  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ack != '0) && ((ack & req) != '0) |=> ack == $past(ack))
    else $error("ack changed while the granted req was high");

  // release takes exactly one cycle
  a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    (ack != '0) && ((ack & req) == '0) |=> ack == '0)
    else $error("ack did not fall one cycle after req fell");

  a_overrun_granted: assert property (@(posedge clk) disable iff (!rst_n)
    overrun |-> ack != '0)
    else $error("overrun high without a grant");

endmodule : arb_props

bind arb_top arb_props i_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .req     (req),
  .ack     (ack),
  .overrun (overrun)
);

/* tests/arb_tb.sv */
// ********************************************************************
// arbiter testbench, table-driven client requests
// checks winners, four-phase order and the overrun flag
// ********************************************************************

`timescale 1ns/1ps

module arb_tb import arb_cfg_pkg::*; ();

  localparam int NUM_ROWS       = 10;
  localparam int TIMEOUT_CYCLES = 100;

  // one row per step
  // mask added to the held losers, hold length after ack and expected winner
  // lowest pending wins after reset or after client 0, highest otherwise
  localparam client_vec_t ROW_MASK [NUM_ROWS] = '{
    8'h20, 8'h01, 8'h49, 8'h48, 8'h40, 8'h01, 8'h84, 8'h80, 8'h12, 8'h02
  };
  localparam int ROW_HOLD [NUM_ROWS] = '{18, 3, 5, 20, 2, 6, 3, 24, 10, 4};
  localparam client_vec_t ROW_WIN [NUM_ROWS] = '{
    8'h20, 8'h01, 8'h01, 8'h08, 8'h40, 8'h01, 8'h04, 8'h80, 8'h10, 8'h02
  };

  logic        clk;
  logic        rst_n;
  client_vec_t req;
  client_vec_t ack;
  logic        overrun;

  int          errors;
  int          checks;
  int          ack_age;
  bit          timed_out;
  integer      seed;

  arb_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .overrun (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // edges since ack rose
  // counted from the ack value seen before each edge
  // overrun is expected once this reaches HOLD_LIMIT
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_age <= 0;
    end else if (ack == '0) begin
      ack_age <= 0;
    end else begin
      ack_age <= ack_age + 1;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // overrun follows the grant age on every cycle
  always @(negedge clk) begin
    if (rst_n === 1'b1) begin
      check_val("overrun", 32'(overrun), 32'((ack != '0) && (ack_age >= HOLD_LIMIT)));
    end
  end

  // sampled on falling edges, away from the DUT updates
  task automatic wait_ack(input bit want_set, input int row);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (((ack != '0) != want_set) && (n < TIMEOUT_CYCLES));
    if ((ack != '0) != want_set) begin
      timed_out = 1'b1;
      $display("timeout in row %0d: ack did not %s within %0d cycles",
               row, want_set ? "rise" : "fall", TIMEOUT_CYCLES);
    end
  endtask

  initial begin
    int          gap;
    client_vec_t win;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    seed      = 32'hfb9a_770c;
    rst_n     = 1'b0;
    req       = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("ack", 32'(ack), 32'h0);
    check_val("overrun", 32'(overrun), 32'h0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      // random idle gap
      // held losers may be granted meanwhile
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(posedge clk);
      @(posedge clk);
      req <= req | ROW_MASK[r];
      wait_ack(1'b1, r);
      if (timed_out) break;
      win = ROW_WIN[r];
      check_val("ack", 32'(ack), 32'(win));
      // ack must stay put while the winner keeps req high
      repeat (ROW_HOLD[r]) begin
        @(negedge clk);
        check_val("ack", 32'(ack), 32'(win));
      end
      @(posedge clk);
      req <= req & ~win;
      wait_ack(1'b0, r);
      if (timed_out) break;
    end

    $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : arb_tb
